//--- Makefile
# Verilator build and run for the video timing subsystem

VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := video_timing_tb
FILELIST  := project.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := TEST OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/video_timing_tb.sv
// Testbench for the video timing subsystem
// Clock, reset, LFSR colour source and the DUT instance
// Directed tests for pixel enable, sync windows, blanking and the VBlank interrupt

`timescale 1ns/1ps

module video_timing_tb;

	import video_timing_pkg::*;
	import pixel_pkg::*;

	localparam int CEN_DIVIDE   = 2;
	localparam int COLOR_BITS   = 12;
	localparam int LINE_PIXELS  = 384;
	localparam int FRAME_LINES  = 264;
	localparam int FRAME_PIXELS = LINE_PIXELS * FRAME_LINES;
	localparam int FRAME_CLKS   = FRAME_PIXELS * CEN_DIVIDE;

	logic                  clk = 1'b0;
	logic                  reset;
	center_t               h_center;
	center_t               v_center;
	logic                  irq_enable;
	logic                  irq_ack;
	logic [COLOR_BITS-1:0] color_in;
	logic                  pixel_cen;
	count_t                h_count;
	count_t                v_count;
	logic                  n_hsync;
	logic                  n_vsync;
	logic                  sync;
	logic                  vblk;
	logic                  n_vblk;
	logic                  n_h256_en;
	logic                  irq;
	logic [COLOR_BITS-1:0] color_out;
	logic                  blank;

	int          error_count;
	int          tests_run;
	logic [31:0] lfsr_state;

	video_timing_top #(
		.CEN_DIVIDE (CEN_DIVIDE),
		.COLOR_BITS (COLOR_BITS)
	) dut (
		.clk        (clk),
		.reset      (reset),
		.h_center   (h_center),
		.v_center   (v_center),
		.irq_enable (irq_enable),
		.irq_ack    (irq_ack),
		.color_in   (color_in),
		.pixel_cen  (pixel_cen),
		.h_count    (h_count),
		.v_count    (v_count),
		.n_hsync    (n_hsync),
		.n_vsync    (n_vsync),
		.sync       (sync),
		.vblk       (vblk),
		.n_vblk     (n_vblk),
		.n_h256_en  (n_h256_en),
		.irq        (irq),
		.color_out  (color_out),
		.blank      (blank)
	);

	// 4 ns master clock
	always #2 clk = ~clk;

	// ==========================================================
	// Helpers
	// ==========================================================

	// Fibonacci LFSR with taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	// One LFSR step for every colour bit
	function automatic logic [COLOR_BITS-1:0] random_color();
		logic [COLOR_BITS-1:0] value;
		value = '0;
		for (int i = 0; i < COLOR_BITS; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[COLOR_BITS-2:0], lfsr_state[0]};
		end
		return value;
	endfunction

	task automatic report_mismatch(input string name, input int expected, input int actual);
		$display("Mismatch at %0t: %s expected 0x%0h, got 0x%0h",
			$time, name, expected, actual);
		error_count++;
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout at %0t while waiting for %s", $time, what);
		$display("TEST FAILED");
		$finish;
	endtask

	task automatic finish_test(input string name, input int start_errors);
		tests_run++;
		$display("%s: %0d errors", name, error_count - start_errors);
	endtask

	// Returns at the falling clk edge of a pixel enable, where the counters are stable
	task automatic wait_cen();
		int n;
		n = 0;
		@(negedge clk);
		while (!pixel_cen) begin
			n++;
			if (n > 4 * CEN_DIVIDE) report_timeout("pixel enable");
			@(negedge clk);
		end
	endtask

	task automatic wait_h_count(input int value);
		int n;
		n = 0;
		wait_cen();
		while (int'(h_count) != value) begin
			n++;
			if (n > 3 * LINE_PIXELS) report_timeout("horizontal count");
			wait_cen();
		end
	endtask

	// ==========================================================
	// Directed tests
	// ==========================================================

	task automatic check_reset_state();
		int start_errors;
		start_errors = error_count;
		if (h_count !== '0) report_mismatch("h_count", 0, int'(h_count));
		if (v_count !== '0) report_mismatch("v_count", 0, int'(v_count));
		if (vblk !== 1'b1) report_mismatch("vblk", 1, int'(vblk));
		if (n_vblk !== 1'b0) report_mismatch("n_vblk", 0, int'(n_vblk));
		if (irq !== 1'b0) report_mismatch("irq", 0, int'(irq));
		if (blank !== 1'b1) report_mismatch("blank", 1, int'(blank));
		if (color_out !== BLACK) report_mismatch("color_out", int'(BLACK), int'(color_out));
		finish_test("reset state", start_errors);
	endtask

	task automatic check_line_timing();
		int start_errors;
		int gap;
		int pulses;
		int expected;
		start_errors = error_count;
		wait_cen();
		// A pulse every CEN_DIVIDE cycles and never two in a row
		for (int p = 0; p < 8; p++) begin
			gap = 1;
			@(negedge clk);
			while (!pixel_cen) begin
				if (gap > 4 * CEN_DIVIDE) report_timeout("pixel enable pulse");
				@(negedge clk);
				gap++;
			end
			if (gap != CEN_DIVIDE) report_mismatch("pixel_cen period", CEN_DIVIDE, gap);
		end
		wait_h_count(int'(H_LINE_START));
		pulses = 0;
		expected = int'(H_LINE_START);
		while (pulses == 0 || int'(h_count) != int'(H_LINE_START)) begin
			if (pulses > 2 * LINE_PIXELS) report_timeout("end of line");
			expected = (expected == int'(H_LAST)) ? int'(H_LINE_START) : expected + 1;
			wait_cen();
			pulses++;
			if (int'(h_count) != expected) report_mismatch("h_count", expected, int'(h_count));
			// The half-line enable marks the last pixel before the visible half
			if (n_h256_en !== (expected == 255)) begin
				report_mismatch("n_h256_en", int'(expected == 255), int'(n_h256_en));
			end
		end
		if (pulses != LINE_PIXELS) report_mismatch("pixels per line", LINE_PIXELS, pulses);
		finish_test("pixel enable and line", start_errors);
	endtask

	task automatic check_hsync_window(input int hc);
		int start_errors;
		int low_bound;
		int high_bound;
		int h;
		int expected;
		start_errors = error_count;
		@(posedge clk);
		#1;
		h_center = center_t'(hc);
		// Low bits pull both bounds down, bit 3 pushes them up by 7
		low_bound  = 175 - (hc % 8) + ((hc >= 8) ? 7 : 0);
		high_bound = 208 - (hc % 8) + ((hc >= 8) ? 7 : 0);
		wait_h_count(int'(H_LINE_START));
		for (int p = 0; p < LINE_PIXELS; p++) begin
			h = int'(h_count);
			expected = (h > low_bound && h < high_bound) ? 0 : 1;
			if (int'(n_hsync) != expected) report_mismatch("n_hsync", expected, int'(n_hsync));
			wait_cen();
		end
		finish_test($sformatf("hsync window, h_center %0d", hc), start_errors);
	endtask

	task automatic check_vsync_frame(input int vc, input int hc);
		int   start_errors;
		int   first_line;
		int   lines;
		int   n;
		int   prev_line;
		logic prev_vsync;
		logic found;
		start_errors = error_count;
		@(posedge clk);
		#1;
		v_center = center_t'(vc);
		h_center = center_t'(hc);
		first_line = 248 - vc + ((hc >= 8) ? 1 : 0);
		// The frame in which the centering changed may be irregular, so skip it
		prev_vsync = 1'b0;
		found = 1'b0;
		n = 0;
		while (!found) begin
			wait_cen();
			n++;
			if (n > 3 * FRAME_PIXELS) report_timeout("vertical sync");
			found = prev_vsync && !n_vsync;
			prev_vsync = n_vsync;
		end
		lines = 0;
		n = 0;
		found = 1'b0;
		prev_line = int'(v_count);
		while (!found) begin
			wait_cen();
			n++;
			if (n > 2 * FRAME_PIXELS) report_timeout("next vertical sync");
			if (sync !== (n_hsync ^ n_vsync)) begin
				report_mismatch("sync", int'(n_hsync ^ n_vsync), int'(sync));
			end
			if (int'(v_count) != prev_line) lines++;
			if (!prev_vsync && n_vsync) begin
				if (lines != 9) report_mismatch("vsync length", 9, lines);
			end else if (prev_vsync && !n_vsync) begin
				if (int'(v_count) != first_line) begin
					report_mismatch("v_count at vsync", first_line, int'(v_count));
				end
				if (lines != FRAME_LINES) report_mismatch("lines per frame", FRAME_LINES, lines);
				found = 1'b1;
			end
			prev_line = int'(v_count);
			prev_vsync = n_vsync;
		end
		finish_test($sformatf("frame and vsync, v_center %0d h_center %0d", vc, hc),
			start_errors);
	endtask

	task automatic check_vblank();
		int   start_errors;
		int   phase;
		int   n;
		int   line;
		logic prev_vblk;
		start_errors = error_count;
		@(posedge clk);
		#1;
		v_center = '0;
		h_center = '0;
		wait_cen();
		prev_vblk = vblk;
		phase = 0;
		n = 0;
		// Phase 0 waits for the start of blanking, phase 1 for its end
		while (phase < 2) begin
			wait_cen();
			n++;
			if (n > 2 * FRAME_PIXELS) report_timeout("vertical blanking edges");
			line = int'(v_count);
			if (n_vblk !== ~vblk) report_mismatch("n_vblk", int'(~vblk), int'(n_vblk));
			if (!prev_vblk && vblk) begin
				if (line != 496) report_mismatch("v_count at vblk rise", 496, line);
				phase = 1;
			end else if (prev_vblk && !vblk && phase == 1) begin
				if (line != 17 && line != 272) report_mismatch("v_count at vblk fall", 272, line);
				phase = 2;
			end
			prev_vblk = vblk;
		end
		finish_test("vertical blanking", start_errors);
	endtask

	task automatic check_interrupt();
		int   start_errors;
		int   n;
		int   rises;
		logic prev_vblk;
		start_errors = error_count;
		@(posedge clk);
		#1;
		irq_enable = 1'b1;
		@(negedge clk);
		if (irq !== 1'b0) report_mismatch("irq", 0, int'(irq));
		n = 0;
		while (irq !== 1'b1) begin
			n++;
			if (n > 2 * FRAME_CLKS) report_timeout("interrupt");
			@(negedge clk);
		end
		if (vblk !== 1'b1) report_mismatch("vblk at irq", 1, int'(vblk));
		if (int'(v_count) != 496) report_mismatch("v_count at irq", 496, int'(v_count));
		// The line stays up until the CPU acknowledges it
		repeat (32) begin
			@(negedge clk);
			if (irq !== 1'b1) report_mismatch("irq", 1, int'(irq));
		end
		@(posedge clk);
		#1;
		irq_ack = 1'b1;
		@(posedge clk);
		#1;
		irq_ack = 1'b0;
		@(negedge clk);
		if (irq !== 1'b0) report_mismatch("irq after ack", 0, int'(irq));
		// Masked, a whole frame must pass without a request
		@(posedge clk);
		#1;
		irq_enable = 1'b0;
		rises = 0;
		prev_vblk = vblk;
		for (int c = 0; c < FRAME_CLKS + LINE_PIXELS * CEN_DIVIDE; c++) begin
			@(negedge clk);
			if (irq !== 1'b0) report_mismatch("irq while masked", 0, int'(irq));
			if (!prev_vblk && vblk) rises++;
			prev_vblk = vblk;
		end
		if (rises == 0) begin
			$display("No start of vertical blanking was seen while the interrupt was masked");
			error_count++;
		end
		finish_test("vblank interrupt", start_errors);
	endtask

	task automatic check_blanking();
		int                    start_errors;
		int                    visible;
		int                    blanked;
		logic                  have_expected;
		logic                  exp_blank;
		logic [COLOR_BITS-1:0] exp_color;
		start_errors = error_count;
		visible = 0;
		blanked = 0;
		have_expected = 1'b0;
		exp_blank = 1'b1;
		exp_color = BLACK;
		@(posedge clk);
		#1;
		color_in = random_color();
		for (int p = 0; p < FRAME_PIXELS + LINE_PIXELS; p++) begin
			wait_cen();
			// Output shows the pixel sampled at the previous enable
			if (have_expected) begin
				if (blank !== exp_blank) report_mismatch("blank", int'(exp_blank), int'(blank));
				if (color_out !== exp_color) begin
					report_mismatch("color_out", int'(exp_color), int'(color_out));
				end
			end
			exp_blank = !h_count[8] || vblk;
			exp_color = exp_blank ? BLACK : color_in;
			if (exp_blank) blanked++;
			else visible++;
			have_expected = 1'b1;
			// New colour right after the enable edge, held for the whole pixel
			@(posedge clk);
			#1;
			color_in = random_color();
		end
		if (visible == 0 || blanked == 0) begin
			$display("Blanking test did not cover both visible and blanked pixels");
			error_count++;
		end
		finish_test("colour blanking", start_errors);
	endtask

	// ==========================================================
	// Test sequence
	// ==========================================================

	initial begin
		reset = 1'b0;
		h_center = '0;
		v_center = '0;
		irq_enable = 1'b0;
		irq_ack = 1'b0;
		color_in = '0;
		lfsr_state = 32'h5651208e;
		error_count = 0;
		tests_run = 0;
		// Five clock cycles in reset
		repeat (4) @(posedge clk);
		@(negedge clk);
		check_reset_state();
		@(posedge clk);
		#1;
		reset = 1'b1;
		check_line_timing();
		check_hsync_window(0);
		check_hsync_window(5);
		check_hsync_window(11);
		check_vsync_frame(0, 0);
		check_vsync_frame(4, 8);
		check_vblank();
		check_interrupt();
		check_blanking();
		$display("Tests run: %0d, errors: %0d", tests_run, error_count);
		if (error_count == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- design/k082_timing.sv
// 082-style video timing generator
// Horizontal and vertical raster counters with the chip's reload points,
// registered vertical blanking and the one-pixel VBlank interrupt strobe,
// centered horizontal and vertical sync and the composite sync

`timescale 1ns/1ps

module k082_timing (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      cen,
	input  video_timing_pkg::center_t h_center,
	input  video_timing_pkg::center_t v_center,
	output video_timing_pkg::count_t  h_count,
	output video_timing_pkg::count_t  v_count,
	output logic                      n_hsync,
	output logic                      n_vsync,
	output logic                      sync,
	output logic                      vblk,
	output logic                      n_vblk,
	output logic                      n_h256_en,
	output logic                      vblk_irq_strobe
);

	import video_timing_pkg::*;

	// ==========================================================
	// Vertical range
	// ==========================================================

	// The vertical centering input moves the whole frame range down
	count_t v_start;
	count_t v_last;

	assign v_start = V_BASE_START - count_t'(v_center);
	assign v_last  = V_LAST_BASE - count_t'(v_center);

	// Vertical blanking ends on either of the two release lines
	logic vblk_off_line;

	assign vblk_off_line = (v_count == VBLANK_OFF_LINES[0]) ||
		(v_count == VBLANK_OFF_LINES[1]);

	// ==========================================================
	// Counters and blanking flags
	// ==========================================================

	// After reset both counters start from 0, so the first line is 512 pixels
	// long and passes H_FIRST_STEP, where the vertical count steps one extra time
	// Every following line runs from H_LINE_START to H_LAST
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			h_count         <= '0;
			v_count         <= '0;
			vblk            <= 1'b1;
			vblk_irq_strobe <= 1'b0;
		end else if (cen) begin
			// Horizontal count and line reload
			if (h_count == H_LAST) begin
				h_count <= H_LINE_START;
			end else begin
				h_count <= h_count + 9'd1;
			end

			// The strobe only lasts the one pixel in which it was set
			vblk_irq_strobe <= 1'b0;

			if (h_count == H_FIRST_STEP) begin
				v_count <= v_count + 9'd1;
			end else if (h_count == V_STEP_H) begin
				// Frame wrap to the centered reload line
				if (v_count == v_last) begin
					v_count <= v_start;
				end else begin
					v_count <= v_count + 9'd1;
				end

				// Blanking changes only at the vertical step point
				if (v_count == VBLANK_ON_LINE) begin
					vblk            <= 1'b1;
					vblk_irq_strobe <= 1'b1;
				end else if (vblk_off_line) begin
					vblk <= 1'b0;
				end
			end
		end
	end

	// The chip offers both blanking polarities
	assign n_vblk = ~vblk;

	// Active high at the last pixel of the left half of the counter range
	assign n_h256_en = (h_count == 9'd255);

	// ==========================================================
	// Sync decode
	// ==========================================================

	// Low three centering bits pull the window left, bit 3 pushes it right
	count_t hsync_shift;
	count_t hsync_low;
	count_t hsync_high;

	assign hsync_shift = h_center[3] ? HSYNC_SHIFT : 9'd0;
	assign hsync_low   = HSYNC_LOW_BASE - count_t'(h_center[2:0]) + hsync_shift;
	assign hsync_high  = HSYNC_HIGH_BASE - count_t'(h_center[2:0]) + hsync_shift;

	// Both bounds are exclusive
	assign n_hsync = ~((h_count > hsync_low) && (h_count < hsync_high));

	// Vertical sync starts at the reload line
	// When the screen moves right it also moves one line up
	count_t vsync_first;
	count_t vsync_last;

	assign vsync_first = v_start + count_t'(h_center[3]);
	assign vsync_last  = vsync_first + VSYNC_LINES - 9'd1;

	assign n_vsync = ~((v_count >= vsync_first) && (v_count <= vsync_last));

	// Composite sync as the chip gives it
	assign sync = n_hsync ^ n_vsync;

endmodule

//--- design/pixel_clock_enable.sv
// Pixel clock enable divider
// A down counter that gives one cen strobe every CEN_DIVIDE clk cycles

`timescale 1ns/1ps

module pixel_clock_enable #(
	parameter int CEN_DIVIDE = 2
) (
	input  logic clk,
	input  logic reset,
	output logic cen
);

	// A divide of one still needs a one-bit counter
	localparam int CNT_BITS = (CEN_DIVIDE > 1) ? $clog2(CEN_DIVIDE) : 1;
	localparam logic [CNT_BITS-1:0] RELOAD = CNT_BITS'(CEN_DIVIDE - 1);

	logic [CNT_BITS-1:0] count;

	// Counts down to zero and reloads, so zero comes once per period
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			count <= RELOAD;
		end else if (count == '0) begin
			count <= RELOAD;
		end else begin
			count <= count - 1'b1;
		end
	end

	// With CEN_DIVIDE of 1 the counter stays at zero and cen is held high
	assign cen = (count == '0);

endmodule

//--- design/pixel_pkg.sv
// Pixel colour definitions shared by the blanking stage
// Default colour word width and the black level

package pixel_pkg;

	// ==========================================================
	// Colour word
	// ==========================================================

	// Four bits per channel for a 4-4-4 RGB board
	localparam int COLOR_BITS_DEFAULT = 12;

	// Forced onto the output outside the visible area
	localparam logic [COLOR_BITS_DEFAULT-1:0] BLACK = '0;

endpackage

//--- design/vblank_irq.sv
// VBlank interrupt latch
// Turns the one-pixel VBlank strobe into a CPU interrupt line
// that the CPU masks with irq_enable and clears with irq_ack

`timescale 1ns/1ps

module vblank_irq (
	input  logic clk,
	input  logic reset,
	input  logic vblk_irq_strobe,
	input  logic irq_enable,
	input  logic irq_ack,
	output logic irq
);

	// ==========================================================
	// Set and clear conditions
	// ==========================================================

	logic irq_set;
	logic irq_clear;

	// A strobe only counts while the CPU has the interrupt unmasked
	assign irq_set = vblk_irq_strobe && irq_enable;

	// Masking the interrupt also drops a pending request
	assign irq_clear = irq_ack || !irq_enable;

	// ==========================================================
	// Latch
	// ==========================================================

	// Set is tested first, so a strobe in the same cycle as an ack
	// leaves the line high and the new frame's interrupt survives
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			irq <= 1'b0;
		end else if (irq_set) begin
			irq <= 1'b1;
		end else if (irq_clear) begin
			irq <= 1'b0;
		end
	end

endmodule

//--- design/video_blank_stage.sv
// Video blanking stage
// Registers the pixel colour on each pixel enable and forces it to black
// outside the visible area, together with a pixel-aligned blank flag

`timescale 1ns/1ps

module video_blank_stage #(
	parameter int COLOR_BITS = pixel_pkg::COLOR_BITS_DEFAULT
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  cen,
	input  logic                  h_visible,
	input  logic                  vblk,
	input  logic [COLOR_BITS-1:0] color_in,
	output logic [COLOR_BITS-1:0] color_out,
	output logic                  blank
);

	import pixel_pkg::*;

	// ==========================================================
	// Blank decode
	// ==========================================================

	// Black at the width of this stage's colour word
	localparam logic [COLOR_BITS-1:0] BLACK_WORD = COLOR_BITS'(BLACK);

	// Blanked when outside the visible half of the line or in vertical blanking
	logic blank_next;

	assign blank_next = ~h_visible | vblk;

	// ==========================================================
	// Output register
	// ==========================================================

	// Sampled at the same edge where the counters step, so the output shows
	// the pixel that the counters held just before that edge
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			blank     <= 1'b1;
			color_out <= BLACK_WORD;
		end else if (cen) begin
			blank <= blank_next;
			if (blank_next) begin
				color_out <= BLACK_WORD;
			end else begin
				color_out <= color_in;
			end
		end
	end

endmodule

//--- design/video_timing_pkg.sv
// Raster timing definitions for the 082-style video timing generator
// Counter and centering types, line and frame reload points,
// vertical blanking lines and the sync window constants

package video_timing_pkg;

	// ==========================================================
	// Types
	// ==========================================================

	localparam int COUNT_BITS  = 9;
	localparam int CENTER_BITS = 4;

	// Both raster counters are one 9-bit word, as on the chip
	typedef logic [COUNT_BITS-1:0] count_t;

	// Centering inputs are extras that the real chip does not have
	typedef logic [CENTER_BITS-1:0] center_t;

	// ==========================================================
	// Counter boundaries
	// ==========================================================

	// The horizontal counter reloads here, giving 384 pixels per line
	localparam count_t H_LINE_START = 9'd128;
	localparam count_t H_LAST       = 9'd511;

	// Only reached on the first line after reset, where the vertical count also steps
	localparam count_t H_FIRST_STEP = 9'd48;

	// The vertical counter steps once per line at this horizontal count
	localparam count_t V_STEP_H     = 9'd176;

	// Vertical reload and wrap points, both moved down by v_center
	localparam count_t V_BASE_START = 9'd248;
	localparam count_t V_LAST_BASE  = 9'd511;

	// Vertical blanking starts on one line and ends on either of two
	localparam count_t VBLANK_ON_LINE       = 9'd495;
	localparam count_t VBLANK_OFF_LINES [2] = '{9'd16, 9'd271};

	// Exclusive horizontal sync bounds before centering
	localparam count_t HSYNC_LOW_BASE  = 9'd175;
	localparam count_t HSYNC_HIGH_BASE = 9'd208;
	localparam count_t HSYNC_SHIFT     = 9'd7;

	// Vertical sync length in lines
	localparam count_t VSYNC_LINES = 9'd9;

endpackage

//--- design/video_timing_top.sv
// Video timing subsystem top level
// Pixel enable divider, 082-style timing generator, VBlank interrupt
// latch and blanking stage wired together

`timescale 1ns/1ps

module video_timing_top #(
	parameter int CEN_DIVIDE = 2,
	parameter int COLOR_BITS = pixel_pkg::COLOR_BITS_DEFAULT
) (
	input  logic                      clk,
	input  logic                      reset,
	input  video_timing_pkg::center_t h_center,
	input  video_timing_pkg::center_t v_center,
	input  logic                      irq_enable,
	input  logic                      irq_ack,
	input  logic [COLOR_BITS-1:0]     color_in,
	output logic                      pixel_cen,
	output video_timing_pkg::count_t  h_count,
	output video_timing_pkg::count_t  v_count,
	output logic                      n_hsync,
	output logic                      n_vsync,
	output logic                      sync,
	output logic                      vblk,
	output logic                      n_vblk,
	output logic                      n_h256_en,
	output logic                      irq,
	output logic [COLOR_BITS-1:0]     color_out,
	output logic                      blank
);

	// ==========================================================
	// Internal wires
	// ==========================================================

	// One-pixel request from the timing generator to the interrupt latch
	logic vblk_irq_strobe;

	// The right half of the counter range is the visible part of a line
	logic h_visible;

	assign h_visible = h_count[8];

	// ==========================================================
	// Instances
	// ==========================================================

	// Pixel rate from the master clock
	pixel_clock_enable #(
		.CEN_DIVIDE (CEN_DIVIDE)
	) u_pixel_clock_enable (
		.clk   (clk),
		.reset (reset),
		.cen   (pixel_cen)
	);

	k082_timing u_k082_timing (
		.clk             (clk),
		.reset           (reset),
		.cen             (pixel_cen),
		.h_center        (h_center),
		.v_center        (v_center),
		.h_count         (h_count),
		.v_count         (v_count),
		.n_hsync         (n_hsync),
		.n_vsync         (n_vsync),
		.sync            (sync),
		.vblk            (vblk),
		.n_vblk          (n_vblk),
		.n_h256_en       (n_h256_en),
		.vblk_irq_strobe (vblk_irq_strobe)
	);

	// CPU interrupt line
	vblank_irq u_vblank_irq (
		.clk             (clk),
		.reset           (reset),
		.vblk_irq_strobe (vblk_irq_strobe),
		.irq_enable      (irq_enable),
		.irq_ack         (irq_ack),
		.irq             (irq)
	);

	// Colour path, one pixel behind the counters
	video_blank_stage #(
		.COLOR_BITS (COLOR_BITS)
	) u_video_blank_stage (
		.clk       (clk),
		.reset     (reset),
		.cen       (pixel_cen),
		.h_visible (h_visible),
		.vblk      (vblk),
		.color_in  (color_in),
		.color_out (color_out),
		.blank     (blank)
	);

endmodule

//--- project.f
design/video_timing_pkg.sv
design/pixel_pkg.sv
design/pixel_clock_enable.sv
design/k082_timing.sv
design/vblank_irq.sv
design/video_blank_stage.sv
design/video_timing_top.sv
bench/video_timing_tb.sv
